/* Bender.yml */
package:
  name: mcu_cmd

export_include_dirs:
  - hdl

sources:
  - files:
      - hdl/cmd_pkg.sv
      - hdl/mem_pkg.sv
      - hdl/cmd_config_regs.sv
      - hdl/mem_addr_gen.sv
      - hdl/mem_access_ctrl.sv
      - hdl/readback_mux.sv
      - hdl/mcu_cmd_top.sv
  - target: simulation
    files:
      - verification/mcu_cmd_sva.sv
      - verification/mcu_cmd_tb.sv

/* files.f */
+incdir+hdl
hdl/cmd_pkg.sv
hdl/mem_pkg.sv
hdl/cmd_config_regs.sv
hdl/mem_addr_gen.sv
hdl/mem_access_ctrl.sv
hdl/readback_mux.sv
hdl/mcu_cmd_top.sv
verification/mcu_cmd_sva.sv
verification/mcu_cmd_tb.sv

/* hdl/cmd_config_regs.sv */
`timescale 1ns/100ps
`include "mcu_cmd_consts.svh"

module cmd_config_regs import cmd_pkg::*, mem_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       cmd_ready,
  input  logic       param_ready,
  input  logic [7:0] cmd_data,
  input  logic [7:0] param_data,
  input  byte_cnt_t  spi_byte_cnt,
  output mcu_addr_t  rom_mask_out,
  output mcu_addr_t  saveram_mask_out,
  output mapper_t    mcu_mapper,
  output logic [7:0] feature_bits
);

  cmd_op_t cmd_op;

  // one param byte into its slot, high byte first
  function automatic mcu_addr_t put_byte(input mcu_addr_t cur, input byte_cnt_t cnt,
                                         input logic [7:0] b);
    mcu_addr_t res;
    res = cur;
    case (cnt)
      `FIRST_PARAM:     res[23:16] = b;
      `FIRST_PARAM + 1: res[15:8]  = b;
      `FIRST_PARAM + 2: res[7:0]   = b;
      default: ;
    endcase
    return res;
  endfunction

  assign cmd_op = cmd_op_t'(cmd_data[7:4]);

  always_ff @(posedge clk) begin
    if (rst) begin
      rom_mask_out     <= '0;
      saveram_mask_out <= '0;
      mcu_mapper       <= `MAPPER_RESET;
      feature_bits     <= '0;
    end else if (cmd_ready) begin
      // mapper comes with the command byte itself
      if (cmd_op == op_mapper) begin
        mcu_mapper <= cmd_data[2:0];
      end
    end else if (param_ready) begin
      case (cmd_op)
        op_rom_mask:  rom_mask_out <= put_byte(rom_mask_out, spi_byte_cnt, param_data);
        op_sram_mask: begin
          saveram_mask_out <= put_byte(saveram_mask_out, spi_byte_cnt, param_data);
        end
        default: begin
          if (ext_op_t'(cmd_data) == ext_feature) begin
            feature_bits <= param_data;
          end
        end
      endcase
    end
  end

endmodule

/* hdl/cmd_pkg.sv */
`include "mcu_cmd_consts.svh"

package cmd_pkg;

  // upper nibble of the command byte
  typedef enum logic [3:0] {
    op_set_addr  = 4'h0,
    op_rom_mask  = 4'h1,
    op_sram_mask = 4'h2,
    op_mapper    = 4'h3,
    op_read      = 4'h8,
    op_write     = 4'h9,
    op_extended  = 4'hF
  } cmd_op_t;

  // full byte of the extended commands
  typedef enum logic [7:0] {
    ext_feature   = 8'hED,
    ext_signature = 8'hF0,
    ext_echo      = 8'hFF
  } ext_op_t;

  typedef logic [`SPI_CNT_W-1:0] byte_cnt_t;

endpackage

/* hdl/mcu_cmd_consts.svh */
`ifndef MCU_CMD_CONSTS_SVH
`define MCU_CMD_CONSTS_SVH

//////////////////////////////
// widths
//////////////////////////////

// memory address and both masks
`define MCU_ADDR_W 24

// spi byte counter
`define SPI_CNT_W 32

//////////////////////////////
// byte positions and fixed values
//////////////////////////////

// params start after the command byte
`define FIRST_PARAM 2

// answer to the signature command
`define SIGNATURE_BYTE 8'hA5

// mapper selected out of reset
`define MAPPER_RESET 3'd1

`endif

/* hdl/mcu_cmd_top.sv */
`timescale 1ns/100ps
`include "mcu_cmd_consts.svh"

module mcu_cmd_top import cmd_pkg::*, mem_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       cmd_ready,
  input  logic       param_ready,
  input  logic [7:0] cmd_data,
  input  logic [7:0] param_data,
  input  byte_cnt_t  spi_byte_cnt,
  input  logic       mcu_rq_rdy,
  input  logic [7:0] mcu_data_in,
  output logic       mcu_rrq,
  output logic       mcu_wrq,
  output logic [7:0] mcu_data_out,
  output logic [7:0] spi_data_out,
  output mcu_addr_t  addr_out,
  output mcu_addr_t  rom_mask_out,
  output mcu_addr_t  saveram_mask_out,
  output mapper_t    mcu_mapper,
  output logic [7:0] feature_bits
);

  // one-cycle completion of a memory request
  logic next_addr;

  cmd_config_regs i_cmd_config_regs (
    .clk              (clk),
    .rst              (rst),
    .cmd_ready        (cmd_ready),
    .param_ready      (param_ready),
    .cmd_data         (cmd_data),
    .param_data       (param_data),
    .spi_byte_cnt     (spi_byte_cnt),
    .rom_mask_out     (rom_mask_out),
    .saveram_mask_out (saveram_mask_out),
    .mcu_mapper       (mcu_mapper),
    .feature_bits     (feature_bits)
  );

  mem_addr_gen i_mem_addr_gen (
    .clk          (clk),
    .rst          (rst),
    .param_ready  (param_ready),
    .cmd_data     (cmd_data),
    .param_data   (param_data),
    .spi_byte_cnt (spi_byte_cnt),
    .next_addr    (next_addr),
    .addr_out     (addr_out)
  );

  mem_access_ctrl i_mem_access_ctrl (
    .clk          (clk),
    .rst          (rst),
    .cmd_ready    (cmd_ready),
    .param_ready  (param_ready),
    .cmd_data     (cmd_data),
    .param_data   (param_data),
    .mcu_rq_rdy   (mcu_rq_rdy),
    .mcu_rrq      (mcu_rrq),
    .mcu_wrq      (mcu_wrq),
    .mcu_data_out (mcu_data_out),
    .next_addr    (next_addr)
  );

  readback_mux i_readback_mux (
    .clk          (clk),
    .rst          (rst),
    .cmd_ready    (cmd_ready),
    .param_ready  (param_ready),
    .cmd_data     (cmd_data),
    .param_data   (param_data),
    .mcu_data_in  (mcu_data_in),
    .next_addr    (next_addr),
    .spi_data_out (spi_data_out)
  );

endmodule

/* hdl/mem_access_ctrl.sv */
`timescale 1ns/100ps
`include "mcu_cmd_consts.svh"

module mem_access_ctrl import cmd_pkg::*, mem_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       cmd_ready,
  input  logic       param_ready,
  input  logic [7:0] cmd_data,
  input  logic [7:0] param_data,
  input  logic       mcu_rq_rdy,
  output logic       mcu_rrq,
  output logic       mcu_wrq,
  output logic [7:0] mcu_data_out,
  output logic       next_addr
);

  cmd_op_t       cmd_op;
  access_state_t state;
  logic          rd_start;
  logic          wr_start;
  logic [2:0]    rdy_hist;

  assign cmd_op   = cmd_op_t'(cmd_data[7:4]);
  // reads also fire on the command byte, writes need data
  assign rd_start = (cmd_ready || param_ready) && cmd_op == op_read;
  assign wr_start = param_ready && cmd_op == op_write;

  //////////////////////////////
  // request strobes and state
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      mcu_rrq <= 1'b0;
      mcu_wrq <= 1'b0;
      state   <= acc_idle;
    end else begin
      mcu_rrq <= rd_start;
      mcu_wrq <= wr_start;
      if (rd_start) begin
        state <= acc_read;
      end else if (wr_start) begin
        state <= acc_write;
      end else if (next_addr) begin
        state <= acc_idle;
      end
    end
  end

  // write byte held until completion
  always_ff @(posedge clk) begin
    if (wr_start) begin
      mcu_data_out <= param_data;
    end
  end

  //////////////////////////////
  // completion edge detect
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      rdy_hist  <= '0;
      next_addr <= 1'b0;
    end else begin
      rdy_hist  <= {rdy_hist[1:0], mcu_rq_rdy};
      next_addr <= rdy_hist[2:1] == 2'b01 && state != acc_idle;
    end
  end

endmodule

/* hdl/mem_addr_gen.sv */
`timescale 1ns/100ps
`include "mcu_cmd_consts.svh"

module mem_addr_gen import cmd_pkg::*, mem_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       param_ready,
  input  logic [7:0] cmd_data,
  input  logic [7:0] param_data,
  input  byte_cnt_t  spi_byte_cnt,
  input  logic       next_addr,
  output mcu_addr_t  addr_out
);

  cmd_op_t cmd_op;
  logic    addr_load;
  logic    addr_inc;

  assign cmd_op    = cmd_op_t'(cmd_data[7:4]);
  assign addr_load = param_ready && cmd_op == op_set_addr;

  // bit 3 enables increment, bit 4 skips the command byte
  assign addr_inc = next_addr
                 && (cmd_op == op_read || cmd_op == op_write)
                 && cmd_data[3]
                 && spi_byte_cnt >= byte_cnt_t'(1) + byte_cnt_t'(cmd_data[4]);

  always_ff @(posedge clk) begin
    if (rst) begin
      addr_out <= '0;
    end else if (addr_load) begin
      case (spi_byte_cnt)
        `FIRST_PARAM: begin
          addr_out[23:16] <= param_data;
          addr_out[15:0]  <= '0;
        end
        `FIRST_PARAM + 1: addr_out[15:8] <= param_data;
        `FIRST_PARAM + 2: addr_out[7:0]  <= param_data;
        default: ;
      endcase
    end else if (addr_inc) begin
      addr_out <= addr_out + mcu_addr_t'(1);
    end
  end

endmodule

/* hdl/mem_pkg.sv */
`include "mcu_cmd_consts.svh"

package mem_pkg;

  // address and mask share one width
  typedef logic [`MCU_ADDR_W-1:0] mcu_addr_t;

  typedef logic [2:0] mapper_t;

  // pending memory request
  typedef enum logic [1:0] {
    acc_idle,
    acc_read,
    acc_write
  } access_state_t;

endpackage

/* hdl/readback_mux.sv */
`timescale 1ns/100ps
`include "mcu_cmd_consts.svh"

module readback_mux import cmd_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       cmd_ready,
  input  logic       param_ready,
  input  logic [7:0] cmd_data,
  input  logic [7:0] param_data,
  input  logic [7:0] mcu_data_in,
  input  logic       next_addr,
  output logic [7:0] spi_data_out
);

  cmd_op_t cmd_op;
  ext_op_t ext_op;
  logic    byte_strobe;

  assign cmd_op      = cmd_op_t'(cmd_data[7:4]);
  assign ext_op      = ext_op_t'(cmd_data);
  assign byte_strobe = cmd_ready || param_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      spi_data_out <= '0;
    end else if (cmd_op == op_read && next_addr) begin
      // memory data valid at completion
      spi_data_out <= mcu_data_in;
    end else if (byte_strobe && cmd_op == op_extended) begin
      case (ext_op)
        ext_signature: spi_data_out <= `SIGNATURE_BYTE;
        ext_echo:      spi_data_out <= param_data;
        default: ;
      endcase
    end
  end

endmodule

/* verification/mcu_cmd_sva.sv */
`timescale 1ns/100ps
`include "mcu_cmd_consts.svh"

module mcu_cmd_sva import cmd_pkg::*, mem_pkg::*; (
  input logic       clk,
  input logic       rst,
  input logic       cmd_ready,
  input logic       param_ready,
  input logic [7:0] cmd_data,
  input logic       mcu_rrq,
  input logic       mcu_wrq,
  input logic       mcu_rq_rdy,
  input logic       next_addr,
  input mcu_addr_t  addr_out
);

  int unsigned fail_count = 0;
  logic        rd_strobe;

  assign rd_strobe = (cmd_ready || param_ready) && cmd_data[7:4] == op_read;

  a_rrq_single: assert property (@(posedge clk) disable iff (rst) mcu_rrq |=> !mcu_rrq)
    else begin
      fail_count++;
      $error("mcu_rrq high for two cycles");
    end
  a_wrq_single: assert property (@(posedge clk) disable iff (rst) mcu_wrq |=> !mcu_wrq)
    else begin
      fail_count++;
      $error("mcu_wrq high for two cycles");
    end

  // read request one cycle after its byte strobe
  a_rrq_follows: assert property (@(posedge clk) disable iff (rst) rd_strobe |=> mcu_rrq)
    else begin
      fail_count++;
      $error("mcu_rrq missing after read strobe");
    end
  a_rrq_cause: assert property (@(posedge clk) disable iff (rst) mcu_rrq |-> $past(rd_strobe))
    else begin
      fail_count++;
      $error("mcu_rrq without read strobe");
    end

  a_addr_cause: assert property (@(posedge clk) disable iff (rst)
    !$stable(addr_out) |-> $past(param_ready || next_addr))
    else begin
      fail_count++;
      $error("addr_out changed without cause");
    end

  a_no_strobe_busy: assert property (@(posedge clk) disable iff (rst)
    mcu_rq_rdy |-> !(mcu_rrq || mcu_wrq))
    else begin
      fail_count++;
      $error("request strobe while mcu_rq_rdy high");
    end

endmodule

bind mcu_cmd_top mcu_cmd_sva i_mcu_cmd_sva (.*);

/* verification/mcu_cmd_tb.sv */
`timescale 1ns/100ps
`include "mcu_cmd_consts.svh"

module mcu_cmd_tb import cmd_pkg::*, mem_pkg::*; ();

  logic       clk, rst, cmd_ready, param_ready, mcu_rq_rdy, mcu_rrq, mcu_wrq;
  logic [7:0] cmd_data, param_data, mcu_data_in, mcu_data_out, spi_data_out, feature_bits;
  byte_cnt_t  spi_byte_cnt;
  mcu_addr_t  addr_out, rom_mask_out, saveram_mask_out;
  mapper_t    mcu_mapper;
  logic [7:0] model_mem [mcu_addr_t];
  logic [31:0] lfsr_state = 32'h42a1_4c45;
  int         errors = 0;
  int         timeouts = 0;

  mcu_cmd_top i_mcu_cmd_top (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // galois lfsr stepped once per bit taken
  function automatic logic [7:0] take_bits(input int n);
    logic [7:0] val;
    val = '0;
    repeat (n) begin
      val = {val[6:0], lfsr_state[0]};
      lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h8020_0003 : lfsr_state >> 1;
    end
    return val;
  endfunction

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      errors++;
      $display("ERR %s expected %h got %h", name, exp, act);
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #10;
  endtask

  // one strobe lasting one cycle
  task automatic send_byte(input logic is_cmd, input int cnt, input logic [7:0] data);
    spi_byte_cnt = cnt;
    if (is_cmd) begin
      cmd_data  = data;
      cmd_ready = 1'b1;
    end else begin
      param_data  = data;
      param_ready = 1'b1;
    end
    next_cycle();
    cmd_ready   = 1'b0;
    param_ready = 1'b0;
  endtask

  task automatic send_command3(input logic [7:0] cmd, input logic [23:0] value);
    send_byte(1'b1, 1, cmd);
    for (int i = 0; i < 3; i++) begin
      send_byte(1'b0, `FIRST_PARAM + i, value[23 - 8 * i -: 8]);
    end
  endtask

  task automatic wait_access(input logic is_write, input logic [7:0] wdata);
    int n;
    if (!(mcu_rrq || mcu_wrq)) begin
      errors++;
      $display("no memory request in the cycle after the byte strobe");
      return;
    end
    check_val("mcu_wrq", is_write, mcu_wrq);
    check_val("mcu_rrq", !is_write, mcu_rrq);
    if (is_write) check_val("mcu_data_out", wdata, mcu_data_out);
    n = 0;
    while (!i_mcu_cmd_top.next_addr && n < 40) begin
      next_cycle();
      n++;
    end
    if (n == 40) begin
      timeouts++;
      $display("timeout: memory request never completed");
    end
    next_cycle();
  endtask

  task automatic read_byte(input logic is_cmd, input int cnt, input logic [7:0] data,
                           input logic inc);
    mcu_addr_t prior;
    prior = addr_out;
    send_byte(is_cmd, cnt, data);
    wait_access(1'b0, 8'h00);
    check_val("spi_data_out", model_mem[prior], spi_data_out);
    check_val("addr_out", prior + inc, addr_out);
  endtask

  task automatic write_byte(input int cnt, input logic [7:0] data);
    mcu_addr_t prior;
    prior = addr_out;
    send_byte(1'b0, cnt, data);
    wait_access(1'b1, data);
    check_val("model_mem", data, model_mem[prior]);
    check_val("addr_out", prior + 1, addr_out);
  endtask

  //////////////////////////////
  // memory responder
  //////////////////////////////

  initial begin : mem_responder
    mcu_addr_t a;
    mcu_rq_rdy  = 1'b0;
    mcu_data_in = 8'h00;
    forever begin
      next_cycle();
      if (mcu_rrq || mcu_wrq) begin
        a = addr_out;
        if (mcu_wrq) model_mem[a] = mcu_data_out;
        else if (!model_mem.exists(a)) model_mem[a] = take_bits(8);
        repeat (1 + take_bits(3) % 6) next_cycle();
        mcu_rq_rdy  = 1'b1;
        mcu_data_in = model_mem[a];
        repeat (2) next_cycle();
        mcu_rq_rdy = 1'b0;
      end
    end
  end

  //////////////////////////////
  // test sequence
  //////////////////////////////

  initial begin : run_tests
    int sva_fails;
    rst          = 1'b1;
    cmd_ready    = 1'b0;
    param_ready  = 1'b0;
    cmd_data     = 8'h00;
    param_data   = 8'h00;
    spi_byte_cnt = '0;
    repeat (3) @(posedge clk);
    #10 rst = 1'b0;
    check_val("mcu_rrq", 0, mcu_rrq);
    check_val("mcu_wrq", 0, mcu_wrq);
    check_val("next_addr", 0, i_mcu_cmd_top.next_addr);
    check_val("state", acc_idle, i_mcu_cmd_top.i_mem_access_ctrl.state);
    check_val("addr_out", 0, addr_out);
    check_val("rom_mask_out", 0, rom_mask_out);
    check_val("saveram_mask_out", 0, saveram_mask_out);
    check_val("feature_bits", 0, feature_bits);
    check_val("mcu_mapper", 1, mcu_mapper);

    send_byte(1'b1, 1, 8'h35);
    check_val("mcu_mapper", 5, mcu_mapper);
    send_command3(8'h12, 24'h3fffc0);
    check_val("rom_mask_out", 24'h3fffc0, rom_mask_out);
    send_command3(8'h2a, 24'h012345);
    check_val("saveram_mask_out", 24'h012345, saveram_mask_out);
    send_command3(8'h00, 24'h123456);
    check_val("addr_out", 24'h123456, addr_out);
    send_byte(1'b1, 1, 8'h00);
    send_byte(1'b0, `FIRST_PARAM, 8'h40);
    check_val("addr_out", 24'h400000, addr_out);

    // write four bytes and read them back and past them
    send_byte(1'b1, 1, 8'h98);
    for (int i = 0; i < 4; i++) write_byte(`FIRST_PARAM + i, 8'h5a + 8'h11 * i);
    send_byte(1'b1, 1, 8'h00);
    send_byte(1'b0, `FIRST_PARAM, 8'h40);
    read_byte(1'b1, 1, 8'h88, 1'b1);
    for (int i = 0; i < 5; i++) read_byte(1'b0, `FIRST_PARAM + i, 8'h00, 1'b1);
    read_byte(1'b1, 1, 8'h80, 1'b0);
    for (int i = 0; i < 2; i++) read_byte(1'b0, `FIRST_PARAM + i, 8'h00, 1'b0);

    send_byte(1'b1, 1, 8'hf0);
    check_val("spi_data_out", `SIGNATURE_BYTE, spi_data_out);
    send_byte(1'b1, 1, 8'hff);
    send_byte(1'b0, `FIRST_PARAM, 8'h3c);
    check_val("spi_data_out", 8'h3c, spi_data_out);
    next_cycle();
    send_byte(1'b0, `FIRST_PARAM + 1, 8'hc3);
    check_val("spi_data_out", 8'hc3, spi_data_out);
    send_byte(1'b1, 1, 8'hed);
    send_byte(1'b0, `FIRST_PARAM, 8'h81);
    check_val("feature_bits", 8'h81, feature_bits);

    repeat (3) next_cycle();
    sva_fails = i_mcu_cmd_top.i_mcu_cmd_sva.fail_count;
    $display("errors: %0d, timeouts: %0d, assertion failures: %0d", errors, timeouts, sva_fails);
    if (errors == 0 && timeouts == 0 && sva_fails == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule
